//--- bench/clock_gen.sv
//**************************************************************************
// testbench clock and reset
// 40 ns clock, active low reset held for the first 5 cycles
//**************************************************************************

`timescale 1ns/1ps

module clock_gen (
	output logic CLK,
	output logic RESET_L
);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	initial begin
		RESET_L = 1'b0;
		repeat (5) @(posedge CLK);
		RESET_L <= 1'b1; // released on the 5th rising edge
	end

endmodule

//--- bench/game_core_assertions.sv
//**************************************************************************
// game core assertions
// SD request protocol and tick gating checks on the game core top
//**************************************************************************

`timescale 1ns/1ps

module game_core_assertions (
	input logic                  CLK,
	input logic                  RESET_L,
	input core_pkg::sd_req_t     pre_sd_req,
	input logic                  pre_data_ready,
	input logic                  update_tick,
	input logic                  draw_tick,
	input logic                  song_request_data,
	input core_pkg::boot_state_t core_state
);

	import core_pkg::*;

	int   fail_cnt = 0;
	logic outstanding; // a byte request waits for its data_ready

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			outstanding <= 1'b0;
		else if (pre_sd_req.restart)
			outstanding <= 1'b0;
		else if (pre_sd_req.request_data)
			outstanding <= 1'b1;
		else if (pre_data_ready)
			outstanding <= 1'b0;
	end

	req_not_restart: assert property (@(posedge CLK) disable iff (!RESET_L)
		!(pre_sd_req.request_data && pre_sd_req.restart))
	else begin
		$error("request_data and restart high in the same cycle");
		fail_cnt++;
	end

	one_outstanding: assert property (@(posedge CLK) disable iff (!RESET_L)
		pre_sd_req.request_data |-> !outstanding)
	else begin
		$error("byte request issued while another one is outstanding");
		fail_cnt++;
	end

	ticks_running: assert property (@(posedge CLK) disable iff (!RESET_L)
		(update_tick || draw_tick || song_request_data) |-> core_state == S_RUNNING)
	else begin
		$error("tick or song request outside S_RUNNING");
		fail_cnt++;
	end

endmodule

bind game_core game_core_assertions props (
	.CLK(CLK),
	.RESET_L(RESET_L),
	.pre_sd_req(pre_sd_req),
	.pre_data_ready(pre_data_ready),
	.update_tick(update_tick),
	.draw_tick(draw_tick),
	.song_request_data(song_request_data),
	.core_state(core_state)
);

//--- bench/tb_game_core.sv
//**************************************************************************
// game core testbench
// SD reader and RAM models, boot load and scan checks,
// timebase tick and audio output checks
//**************************************************************************

`timescale 1ns/1ps

module tb_game_core;

	import core_pkg::*;

	localparam int       UPD_P      = 7;
	localparam int       AUD_P      = 5;
	localparam int       DRW_P      = 11;
	localparam int       PLAY_D     = 3;
	localparam int       SKIN_WORDS = 24;
	localparam int       RUN_CYCLES = 120;
	localparam sd_byte_t SONG_SEL   = 8'h2c;
	localparam sd_byte_t SKIN_KIND  = 8'h80;
	localparam sd_byte_t BEAT_KIND  = 8'h00;

	logic           CLK;
	logic           RESET_L;
	sd_byte_t       song_selection = SONG_SEL;
	sd_byte_t       pre_data_in = '0;
	logic           pre_data_ready = 1'b0;
	logic           pre_transmit_finished = 1'b0;
	beat_word_t     beat_rd_data = '0;
	sd_byte_t       song_data_in = '0;
	logic           song_data_ready = 1'b0;
	sd_req_t        pre_sd_req;
	skin_wr_t       skin_wr;
	beat_wr_t       beat_wr;
	beat_rd_t       beat_rd;
	section_table_t section_table;
	logic           update_tick;
	logic           draw_tick;
	logic           song_request_data;
	sd_byte_t       main_audio_out;
	logic           audio_en;
	boot_state_t    core_state;

	sd_byte_t    skin_bytes [0:255];
	sd_byte_t    beat_bytes [0:255];
	int          skin_len;
	int          beat_len;
	int          beat_words;
	skin_word_t  skin_ram [0:32767];
	beat_word_t  beat_ram [0:8191];
	int          skin_wr_cnt = 0;
	int          beat_wr_cnt = 0;
	logic [31:0] rng_state = 32'ha390dcbf;

	bit       serve_skin;
	bit       sd_pending;
	int       sd_wait;
	int       rd_ptr;
	int       restart_cnt = 0;
	sd_byte_t restart_idx [0:1];
	sd_byte_t restart_aux [0:1];

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	clock_gen clk_gen (
		.CLK(CLK),
		.RESET_L(RESET_L)
	);

	game_core #(
		.UPDATE_PERIOD(UPD_P),
		.AUDIO_PERIOD(AUD_P),
		.DRAW_PERIOD(DRW_P),
		.PLAY_DELAY(PLAY_D)
	) UUT (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.song_selection(song_selection),
		.pre_data_in(pre_data_in),
		.pre_data_ready(pre_data_ready),
		.pre_transmit_finished(pre_transmit_finished),
		.beat_rd_data(beat_rd_data),
		.song_data_in(song_data_in),
		.song_data_ready(song_data_ready),
		.pre_sd_req(pre_sd_req),
		.skin_wr(skin_wr),
		.beat_wr(beat_wr),
		.beat_rd(beat_rd),
		.section_table(section_table),
		.update_tick(update_tick),
		.draw_tick(draw_tick),
		.song_request_data(song_request_data),
		.main_audio_out(main_audio_out),
		.audio_en(audio_en),
		.core_state(core_state)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_next();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic skin_word_t skin_fill(input int a);
		return {1'b1, a[14:0]};
	endfunction

	function automatic beat_word_t beat_fill(input int a);
		return {11'h5a3, a[12:0]};
	endfunction

	// first byte of a word is the most significant
	function automatic skin_word_t ref_skin_word(input int w);
		return {skin_bytes[2*w], skin_bytes[2*w+1]};
	endfunction

	function automatic beat_word_t ref_beat_word(input int w);
		return {beat_bytes[3*w], beat_bytes[3*w+1], beat_bytes[3*w+2]};
	endfunction

	// size word in front of each section, next one right behind its data
	function automatic section_table_t ref_table();
		section_table_t t;
		beat_addr_t     a;
		beat_word_t     w;
		t = '0;
		a = '0;
		for (int k = 0; k < NUM_SECTIONS; k++) begin
			w = ref_beat_word(int'(a));
			t.size[k] = w[12:0];
			t.base[k] = a + 1'b1;
			a = t.base[k] + t.size[k];
		end
		return t;
	endfunction

	function automatic bit expect_tick(input int e, input int period);
		return e > 0 && e % period == 0;
	endfunction

	// request one cycle after each audio tick past the start delay
	function automatic bit expect_request(input int e);
		return e > 1 && (e - 1) % AUD_P == 0 && (e - 1) / AUD_P > PLAY_D;
	endfunction

	task automatic build_streams();
		int         sz [0:3];
		int         next_hdr;
		int         sec;
		beat_word_t word;
		skin_len = 2 * SKIN_WORDS + 1; // odd byte at the end
		for (int i = 0; i < skin_len; i++)
			skin_bytes[i] = sd_byte_t'(rand_next());
		beat_words = 4;
		for (int k = 0; k < 4; k++) begin
			sz[k] = 1 + int'(rand_next() % 12);
			beat_words += sz[k];
		end
		next_hdr = 0;
		sec = 0;
		for (int w = 0; w < beat_words; w++) begin
			word = beat_word_t'(rand_next());
			if (w == next_hdr && sec < 4) begin
				word[12:0] = 13'(sz[sec]); // upper bits stay random
				next_hdr = w + 1 + sz[sec];
				sec++;
			end
			beat_bytes[3*w] = word[23:16];
			beat_bytes[3*w+1] = word[15:8];
			beat_bytes[3*w+2] = word[7:0];
		end
		beat_len = 3 * beat_words + 2;
		beat_bytes[beat_len-2] = sd_byte_t'(rand_next());
		beat_bytes[beat_len-1] = sd_byte_t'(rand_next());
		for (int a = 0; a < 32768; a++)
			skin_ram[a] = skin_fill(a);
		for (int a = 0; a < 8192; a++)
			beat_ram[a] = beat_fill(a);
	endtask

	task automatic check(input bit ok, input string what);
		assert (ok) else begin
			$display("FAILED at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_at);
		tests_run++;
		if (errors == errs_at) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d mismatches", tests_run, name, errors - errs_at);
		end
	endtask

	task automatic wait_state(input boot_state_t target);
		do
			@(negedge CLK);
		while (core_state != target);
	endtask

	task automatic check_idle();
		check(!pre_sd_req.request_data && !pre_sd_req.restart, "SD request during reset");
		check(!skin_wr.en_w && !beat_wr.en_w && !beat_rd.en, "RAM port active during reset");
		check(!update_tick && !draw_tick && !song_request_data, "tick during reset");
		check(!audio_en, "audio_en high during reset");
		check(core_state == S_INIT, $sformatf("core_state %s, expected S_INIT",
			core_state.name()));
	endtask

	// SD reader, one byte per request after 1 to 3 cycles
	always @(posedge CLK) begin
		pre_data_ready <= 1'b0;
		if (!RESET_L) begin
			sd_pending = 1'b0;
			pre_transmit_finished <= 1'b0;
		end else if (pre_sd_req.restart) begin
			serve_skin = pre_sd_req.aux_info == SKIN_KIND;
			rd_ptr = 0;
			sd_pending = 1'b0;
			pre_transmit_finished <= 1'b0;
			if (restart_cnt < 2) begin
				restart_idx[restart_cnt] = pre_sd_req.init_index;
				restart_aux[restart_cnt] = pre_sd_req.aux_info;
			end
			restart_cnt++;
		end else begin
			if (pre_sd_req.request_data) begin
				sd_pending = 1'b1;
				sd_wait = int'(rand_next() % 3);
			end
			if (sd_pending) begin
				if (sd_wait == 0) begin
					sd_pending = 1'b0;
					pre_data_in <= serve_skin ? skin_bytes[rd_ptr] : beat_bytes[rd_ptr];
					pre_data_ready <= 1'b1;
					pre_transmit_finished <= rd_ptr == (serve_skin ? skin_len : beat_len) - 1;
					rd_ptr++;
				end else begin
					sd_wait--;
				end
			end
		end
	end

	// block RAMs, beatmap read data one cycle after the address
	always @(posedge CLK) begin
		if (skin_wr.en_w) begin
			skin_ram[skin_wr.addr] = skin_wr.data;
			skin_wr_cnt++;
		end
		if (beat_wr.en_w) begin
			beat_ram[beat_wr.addr] = beat_wr.data;
			beat_wr_cnt++;
		end
		if (beat_rd.en)
			beat_rd_data <= beat_ram[beat_rd.addr];
	end

	// song source answers every request on the next cycle
	always @(posedge CLK) begin
		song_data_ready <= song_request_data;
		if (song_request_data)
			song_data_in <= sd_byte_t'(rand_next());
	end

	initial begin
		int             errs_at;
		section_table_t exp_tbl;
		sd_byte_t       exp_audio;
		build_streams();

		errs_at = errors;
		@(posedge CLK);
		do begin
			@(negedge CLK);
			check_idle();
		end while (!RESET_L);
		finish_test("reset", errs_at);

		errs_at = errors;
		wait_state(S_LOAD_BEATMAP);
		check(restart_cnt == 1, $sformatf("%0d restarts before the beatmap load", restart_cnt));
		check(restart_idx[0] == SONG_SEL && restart_aux[0] == SKIN_KIND,
			$sformatf("skin restart index %h aux %h", restart_idx[0], restart_aux[0]));
		check(skin_wr_cnt == SKIN_WORDS, $sformatf("%0d skin writes, expected %0d",
			skin_wr_cnt, SKIN_WORDS));
		for (int w = 0; w < SKIN_WORDS; w++)
			check(skin_ram[w] == ref_skin_word(w), $sformatf("skin word %0d is %h, expected %h",
				w, skin_ram[w], ref_skin_word(w)));
		check(skin_ram[SKIN_WORDS] == skin_fill(SKIN_WORDS), "odd trailing skin byte written");
		finish_test("skin load", errs_at);

		errs_at = errors;
		wait_state(S_SCAN);
		check(restart_cnt == 2, $sformatf("%0d restarts after the beatmap load", restart_cnt));
		check(restart_idx[1] == SONG_SEL && restart_aux[1] == BEAT_KIND,
			$sformatf("beatmap restart index %h aux %h", restart_idx[1], restart_aux[1]));
		check(beat_wr_cnt == beat_words, $sformatf("%0d beatmap writes, expected %0d",
			beat_wr_cnt, beat_words));
		for (int w = 0; w < beat_words; w++)
			check(beat_ram[w] == ref_beat_word(w), $sformatf("beatmap word %0d is %h, expected %h",
				w, beat_ram[w], ref_beat_word(w)));
		check(beat_ram[beat_words] == beat_fill(beat_words), "partial beatmap word written");
		finish_test("beatmap load", errs_at);

		errs_at = errors;
		wait_state(S_RUNNING);
		exp_tbl = ref_table();
		check(section_table == exp_tbl, $sformatf("section_table %h, expected %h",
			section_table, exp_tbl));
		finish_test("section scan", errs_at);

		// elapsed cycles counted from the first cycle in S_RUNNING
		errs_at = errors;
		exp_audio = '0;
		for (int e = 0; e < RUN_CYCLES; e++) begin
			check(audio_en == 1'b1, $sformatf("audio_en low at running cycle %0d", e));
			check(update_tick == expect_tick(e, UPD_P),
				$sformatf("update_tick %b at running cycle %0d", update_tick, e));
			check(draw_tick == expect_tick(e, DRW_P),
				$sformatf("draw_tick %b at running cycle %0d", draw_tick, e));
			check(song_request_data == expect_request(e),
				$sformatf("song_request_data %b at running cycle %0d", song_request_data, e));
			check(main_audio_out == exp_audio, $sformatf("main_audio_out %h, expected %h",
				main_audio_out, exp_audio));
			if (song_data_ready)
				exp_audio = song_data_in;
			@(negedge CLK);
		end
		finish_test("game clock and audio", errs_at);

		$display("%0d tests run, %0d passed, %0d failed, %0d check errors, %0d assertion errors",
			tests_run, tests_run - tests_failed, tests_failed, errors, UUT.props.fail_cnt);
		if (errors == 0 && UUT.props.fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		int limit;
		#1;
		limit = (skin_len + beat_len) * 4 + 2000;
		repeat (limit) @(posedge CLK);
		$display("watchdog expired after %0d cycles, boot state %s", limit, core_state.name());
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- common/core_pkg.sv
//**************************************************************************
// core package
// shared widths, RAM port structs, SD request bundle and boot states
// for the rhythm game boot and timebase core
//**************************************************************************

package core_pkg;

	localparam int NUM_SECTIONS = 4; // beatmap sections, one per key

	// table kinds understood by the SD reader
	localparam logic [7:0] AUX_SKIN    = 8'h80;
	localparam logic [7:0] AUX_BEATMAP = 8'h00;

	typedef logic [7:0]  sd_byte_t;
	typedef logic [14:0] skin_addr_t;
	typedef logic [15:0] skin_word_t;
	typedef logic [12:0] beat_addr_t;
	typedef logic [23:0] beat_word_t;

	typedef struct packed {
		sd_byte_t init_index;
		sd_byte_t aux_info;
		logic     request_data;
		logic     restart;
	} sd_req_t;

	typedef struct packed {
		logic       en_w;
		skin_addr_t addr;
		skin_word_t data;
	} skin_wr_t;

	typedef struct packed {
		logic       en_w;
		beat_addr_t addr;
		beat_word_t data;
	} beat_wr_t;

	typedef struct packed {
		logic       en;
		beat_addr_t addr;
	} beat_rd_t;

	typedef struct packed {
		beat_addr_t [NUM_SECTIONS-1:0] size;
		beat_addr_t [NUM_SECTIONS-1:0] base;
	} section_table_t;

	typedef enum logic [2:0] {
		S_INIT,
		S_LOAD_SKIN,
		S_W_LOAD_SKIN,
		S_LOAD_BEATMAP,
		S_W_LOAD_BEATMAP,
		S_SCAN,
		S_W_SCAN,
		S_RUNNING
	} boot_state_t;

endpackage

//--- loader/bram_loader.sv
//**************************************************************************
// block RAM loader
// restarts the SD reader for one table, fetches its bytes one at a time,
// packs them MSB first into words and writes them to ascending addresses
//**************************************************************************

`timescale 1ns/1ps

module bram_loader #(
	parameter int                 ADDR_W   = 13,
	parameter int                 BYTES    = 3,
	parameter core_pkg::sd_byte_t AUX_INFO = core_pkg::AUX_BEATMAP
) (
	input  logic                 CLK,
	input  logic                 RESET_L,
	input  logic                 start,
	input  core_pkg::sd_byte_t   song_selection,
	input  core_pkg::sd_byte_t   data_in,
	input  logic                 data_ready,
	input  logic                 transmit_finished,
	output core_pkg::sd_req_t    sd_req,
	output logic                 wr_en,
	output logic [ADDR_W-1:0]    wr_addr,
	output logic [8*BYTES-1:0]   wr_data,
	output logic                 done
);

	localparam int CNT_W = (BYTES > 1) ? $clog2(BYTES) : 1;

	typedef enum logic [1:0] {
		L_IDLE,
		L_RESTART,
		L_REQ,
		L_WAIT
	} load_state_t;

	load_state_t        state;
	logic [CNT_W-1:0]   byte_cnt;
	logic [ADDR_W-1:0]  word_cnt;
	logic [8*BYTES-1:0] shift;
	logic [8*BYTES-1:0] word_next;
	logic               last_byte;

	always_comb begin
		word_next = shift << 8;
		word_next[7:0] = data_in; // first byte ends up on top
	end

	assign last_byte = byte_cnt == CNT_W'(BYTES - 1);

	// index and kind only matter while restart is high
	always_comb begin
		sd_req.init_index   = song_selection;
		sd_req.aux_info     = AUX_INFO;
		sd_req.request_data = state == L_REQ;
		sd_req.restart      = state == L_RESTART;
	end

	assign wr_addr = word_cnt;
	assign wr_data = shift;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= L_IDLE;
			byte_cnt <= '0;
			word_cnt <= '0;
			wr_en <= 1'b0;
			done <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			done <= 1'b0;
			if (wr_en)
				word_cnt <= word_cnt + 1'b1;
			case (state)
				L_IDLE: begin
					if (start) begin
						state <= L_RESTART;
						byte_cnt <= '0;
						word_cnt <= '0;
					end
				end
				L_RESTART: state <= L_REQ;
				L_REQ:     state <= L_WAIT; // one request in flight
				L_WAIT: begin
					if (data_ready) begin
						byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
						wr_en <= last_byte;
						// partial word at the end is dropped
						if (transmit_finished) begin
							state <= L_IDLE;
							done <= 1'b1;
						end else begin
							state <= L_REQ;
						end
					end
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == L_WAIT && data_ready)
			shift <= word_next;
	end

endmodule

//--- logic/boot_sequencer.sv
//**************************************************************************
// boot sequencer
// steps through skin load, beatmap load and section scan, then runs the
// game clock; routes the shared SD request lines and beatmap RAM ports
//**************************************************************************

`timescale 1ns/1ps

module boot_sequencer (
	input  logic                  CLK,
	input  logic                  RESET_L,
	input  logic                  skin_done,
	input  logic                  beat_done,
	input  logic                  scan_done,
	input  core_pkg::sd_req_t     skin_req,
	input  core_pkg::sd_req_t     beat_req,
	input  core_pkg::beat_wr_t    beat_wr_in,
	input  core_pkg::beat_rd_t    scan_rd,
	output logic                  skin_start,
	output logic                  beat_start,
	output logic                  scan_start,
	output logic                  running,
	output logic                  audio_en,
	output core_pkg::sd_req_t     sd_req,
	output core_pkg::beat_wr_t    beat_wr,
	output core_pkg::beat_rd_t    beat_rd,
	output core_pkg::boot_state_t core_state
);

	import core_pkg::*;

	boot_state_t state;
	boot_state_t n_state;

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			state <= S_INIT;
		else
			state <= n_state;
	end

	always_comb begin
		case (state)
			S_INIT:           n_state = S_LOAD_SKIN;
			S_LOAD_SKIN:      n_state = S_W_LOAD_SKIN;
			S_W_LOAD_SKIN:    n_state = skin_done ? S_LOAD_BEATMAP : S_W_LOAD_SKIN;
			S_LOAD_BEATMAP:   n_state = S_W_LOAD_BEATMAP;
			S_W_LOAD_BEATMAP: n_state = beat_done ? S_SCAN : S_W_LOAD_BEATMAP;
			S_SCAN:           n_state = S_W_SCAN;
			S_W_SCAN:         n_state = scan_done ? S_RUNNING : S_W_SCAN;
			S_RUNNING:        n_state = S_RUNNING; // game runs until reset
			default:          n_state = S_INIT;
		endcase
	end

	// start pulses, one cycle each
	assign skin_start = state == S_LOAD_SKIN;
	assign beat_start = state == S_LOAD_BEATMAP;
	assign scan_start = state == S_SCAN;

	assign running = state == S_RUNNING;
	assign audio_en = state == S_RUNNING;
	assign core_state = state;

	// SD reader belongs to whichever loader is active
	always_comb begin
		case (state)
			S_LOAD_SKIN, S_W_LOAD_SKIN:       sd_req = skin_req;
			S_LOAD_BEATMAP, S_W_LOAD_BEATMAP: sd_req = beat_req;
			default:                          sd_req = '0;
		endcase
	end

	// beatmap RAM ports
	always_comb begin
		beat_wr = '0;
		beat_rd = '0;
		if (state == S_LOAD_BEATMAP || state == S_W_LOAD_BEATMAP)
			beat_wr = beat_wr_in;
		if (state == S_SCAN || state == S_W_SCAN)
			beat_rd = scan_rd;
	end

endmodule

//--- logic/game_core.sv
//**************************************************************************
// game core top
// boot loaders, section scanner, boot sequencer and game timebase
//**************************************************************************

`timescale 1ns/1ps

module game_core #(
	// defaults for a 100 MHz system clock
	parameter int UPDATE_PERIOD = 100_000_000 / 1000,
	parameter int AUDIO_PERIOD  = 100_000_000 / 44100,
	parameter int DRAW_PERIOD   = 800 * 525 * 4,
	parameter int PLAY_DELAY    = 44100 * 5 / 2
) (
	input  logic                          CLK,
	input  logic                          RESET_L,
	input  core_pkg::sd_byte_t            song_selection,
	input  core_pkg::sd_byte_t            pre_data_in,
	input  logic                          pre_data_ready,
	input  logic                          pre_transmit_finished,
	input  core_pkg::beat_word_t          beat_rd_data,
	input  core_pkg::sd_byte_t            song_data_in,
	input  logic                          song_data_ready,
	output core_pkg::sd_req_t             pre_sd_req,
	output wire core_pkg::skin_wr_t       skin_wr,
	output core_pkg::beat_wr_t            beat_wr,
	output core_pkg::beat_rd_t            beat_rd,
	output core_pkg::section_table_t      section_table,
	output logic                          update_tick,
	output logic                          draw_tick,
	output logic                          song_request_data,
	output core_pkg::sd_byte_t            main_audio_out,
	output logic                          audio_en,
	output core_pkg::boot_state_t         core_state
);

	import core_pkg::*;

	sd_req_t  skin_req;
	sd_req_t  beat_req;
	wire beat_wr_t beat_wr_ld; // loader side, before routing
	beat_rd_t scan_rd;
	logic     skin_start;
	logic     beat_start;
	logic     scan_start;
	logic     skin_done;
	logic     beat_done;
	logic     scan_done;
	logic     running;

	bram_loader #(
		.ADDR_W(15),
		.BYTES(2),
		.AUX_INFO(AUX_SKIN)
	) skin_loader (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.start(skin_start),
		.song_selection(song_selection),
		.data_in(pre_data_in),
		.data_ready(pre_data_ready),
		.transmit_finished(pre_transmit_finished),
		.sd_req(skin_req),
		.wr_en(skin_wr.en_w),
		.wr_addr(skin_wr.addr),
		.wr_data(skin_wr.data),
		.done(skin_done)
	);

	bram_loader #(
		.ADDR_W(13),
		.BYTES(3),
		.AUX_INFO(AUX_BEATMAP)
	) beat_loader (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.start(beat_start),
		.song_selection(song_selection),
		.data_in(pre_data_in),
		.data_ready(pre_data_ready),
		.transmit_finished(pre_transmit_finished),
		.sd_req(beat_req),
		.wr_en(beat_wr_ld.en_w),
		.wr_addr(beat_wr_ld.addr),
		.wr_data(beat_wr_ld.data),
		.done(beat_done)
	);

	section_scanner scanner (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.start(scan_start),
		.rd_data(beat_rd_data),
		.rd(scan_rd),
		.table_out(section_table),
		.done(scan_done)
	);

	boot_sequencer sequencer (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.skin_done(skin_done),
		.beat_done(beat_done),
		.scan_done(scan_done),
		.skin_req(skin_req),
		.beat_req(beat_req),
		.beat_wr_in(beat_wr_ld),
		.scan_rd(scan_rd),
		.skin_start(skin_start),
		.beat_start(beat_start),
		.scan_start(scan_start),
		.running(running),
		.audio_en(audio_en),
		.sd_req(pre_sd_req),
		.beat_wr(beat_wr),
		.beat_rd(beat_rd),
		.core_state(core_state)
	);

	game_timebase #(
		.UPDATE_PERIOD(UPDATE_PERIOD),
		.AUDIO_PERIOD(AUDIO_PERIOD),
		.DRAW_PERIOD(DRAW_PERIOD),
		.PLAY_DELAY(PLAY_DELAY)
	) timebase (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.running(running),
		.song_data_in(song_data_in),
		.song_data_ready(song_data_ready),
		.update_tick(update_tick),
		.draw_tick(draw_tick),
		.song_request_data(song_request_data),
		.main_audio_out(main_audio_out)
	);

endmodule

//--- logic/game_timebase.sv
//**************************************************************************
// game timebase
// update, draw and audio tick generation, song start delay,
// song byte requests and the main audio output latch
//**************************************************************************

`timescale 1ns/1ps

module game_timebase #(
	parameter int UPDATE_PERIOD = 100000,
	parameter int AUDIO_PERIOD  = 2267,
	parameter int DRAW_PERIOD   = 1680000,
	parameter int PLAY_DELAY    = 110250
) (
	input  logic               CLK,
	input  logic               RESET_L,
	input  logic               running,
	input  core_pkg::sd_byte_t song_data_in,
	input  logic               song_data_ready,
	output logic               update_tick,
	output logic               draw_tick,
	output logic               song_request_data,
	output core_pkg::sd_byte_t main_audio_out
);

	localparam int UPD_W = $clog2(UPDATE_PERIOD + 1);
	localparam int AUD_W = $clog2(AUDIO_PERIOD + 1);
	localparam int DRW_W = $clog2(DRAW_PERIOD + 1);
	localparam int DLY_W = $clog2(PLAY_DELAY + 1);

	logic [UPD_W-1:0] upd_cnt;
	logic [AUD_W-1:0] aud_cnt;
	logic [DRW_W-1:0] drw_cnt;
	logic [DLY_W-1:0] delay_cnt; // audio samples before playback
	logic             audio_tick;
	logic             upd_wrap;
	logic             aud_wrap;
	logic             drw_wrap;
	logic             playing;

	assign upd_wrap = upd_cnt == UPD_W'(UPDATE_PERIOD - 1);
	assign aud_wrap = aud_cnt == AUD_W'(AUDIO_PERIOD - 1);
	assign drw_wrap = drw_cnt == DRW_W'(DRAW_PERIOD - 1);
	assign playing = delay_cnt == DLY_W'(PLAY_DELAY);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			upd_cnt <= '0;
			aud_cnt <= '0;
			drw_cnt <= '0;
			delay_cnt <= '0;
			update_tick <= 1'b0;
			draw_tick <= 1'b0;
			audio_tick <= 1'b0;
			song_request_data <= 1'b0;
			main_audio_out <= '0; // silence until the first sample
		end else begin
			update_tick <= running && upd_wrap;
			draw_tick <= running && drw_wrap;
			audio_tick <= running && aud_wrap;
			if (running) begin
				upd_cnt <= upd_wrap ? '0 : upd_cnt + 1'b1;
				aud_cnt <= aud_wrap ? '0 : aud_cnt + 1'b1;
				drw_cnt <= drw_wrap ? '0 : drw_cnt + 1'b1;
			end
			if (audio_tick && !playing)
				delay_cnt <= delay_cnt + 1'b1;
			song_request_data <= audio_tick && playing; // one byte per sample
			if (song_data_ready)
				main_audio_out <= song_data_in;
		end
	end

endmodule

//--- logic/section_scanner.sv
//**************************************************************************
// beatmap section scanner
// reads the size word in front of each beatmap section and builds the
// table of section sizes and base addresses
//**************************************************************************

`timescale 1ns/1ps

module section_scanner (
	input  logic                     CLK,
	input  logic                     RESET_L,
	input  logic                     start,
	input  core_pkg::beat_word_t     rd_data,
	output core_pkg::beat_rd_t       rd,
	output core_pkg::section_table_t table_out,
	output logic                     done
);

	import core_pkg::*;

	localparam int IDX_W = $clog2(NUM_SECTIONS);
	localparam int SIZE_W = $bits(beat_addr_t);

	logic             busy;
	logic [IDX_W-1:0] idx;   // section being read
	logic [1:0]       phase; // address, wait, wait, capture
	section_table_t   tbl;
	beat_addr_t       cur_addr;

	// size word of section k sits right after section k-1
	always_comb begin
		if (idx == '0)
			cur_addr = '0;
		else
			cur_addr = tbl.base[idx - 1'b1] + tbl.size[idx - 1'b1];
	end

	// address held for all four phases of a section
	always_comb begin
		rd.en = busy;
		rd.addr = cur_addr;
	end

	assign table_out = tbl;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			busy <= 1'b0;
			idx <= '0;
			phase <= '0;
			tbl <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					idx <= '0;
					phase <= '0;
				end
			end else begin
				phase <= phase + 1'b1;
				if (phase == 2'd3) begin
					tbl.size[idx] <= rd_data[SIZE_W-1:0];
					tbl.base[idx] <= cur_addr + 1'b1; // data starts after size word
					idx <= idx + 1'b1;
					if (idx == IDX_W'(NUM_SECTIONS - 1)) begin
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the game core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_game_core -o tb_game_core
# keep running past assertion errors so the testbench reports them
./obj_dir/tb_game_core +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation completed successfully" sim.log

//--- tb.f
common/core_pkg.sv
loader/bram_loader.sv
logic/section_scanner.sv
logic/game_timebase.sv
logic/boot_sequencer.sv
logic/game_core.sv
bench/clock_gen.sv
bench/game_core_assertions.sv
bench/tb_game_core.sv
